// ==== rtl/axi_settings.svh ====
`ifndef AXI_SETTINGS_SVH
`define AXI_SETTINGS_SVH

// address channel widths
`define RA_ADDR_W 32
`define RA_MID_W 4

// slave ID = master index on top of the master ID
`define RA_SID_W 8

// beat and burst fields
`define RA_LEN_W 4
`define RA_SIZE_W 3
`define RA_BURST_W 2

// six mapped slaves plus the default slave
`define RA_NUM_SLAVES 7

`endif

// ==== rtl/axiTypesPkg.sv ====
`include "axi_settings.svh"

package axiTypesPkg;

    // read address and IDs
    typedef logic [`RA_ADDR_W-1:0] axiAddrT;
    typedef logic [`RA_MID_W-1:0] axiMidT;

    // upper bits hold the master index
    typedef logic [`RA_SID_W-1:0] axiSidT;

    // burst control fields
    typedef logic [`RA_LEN_W-1:0] axiLenT;
    typedef logic [`RA_SIZE_W-1:0] axiSizeT;
    typedef logic [`RA_BURST_W-1:0] axiBurstT;

endpackage

// ==== rtl/addrMapPkg.sv ====
package addrMapPkg;

    // value is the bit index into the slave valid/ready vectors
    typedef enum logic [2:0] {
        SEL_ROM     = 3'd0,
        SEL_IM      = 3'd1,
        SEL_DM      = 3'd2,
        SEL_DRAM    = 3'd3,
        SEL_SENSOR  = 3'd4,
        SEL_WDT     = 3'd5,
        SEL_DEFAULT = 3'd6
    } slaveSelT;

    // inclusive base and limit per region
    localparam axiTypesPkg::axiAddrT ROM_BASE = 32'h0000_0000;
    localparam axiTypesPkg::axiAddrT ROM_LIMIT = 32'h0000_3FFF;

    localparam axiTypesPkg::axiAddrT IM_BASE = 32'h0001_0000;
    localparam axiTypesPkg::axiAddrT IM_LIMIT = 32'h0001_FFFF;

    localparam axiTypesPkg::axiAddrT DM_BASE = 32'h0002_0000;
    localparam axiTypesPkg::axiAddrT DM_LIMIT = 32'h0002_FFFF;

    // peripherals, 1 KB each
    localparam axiTypesPkg::axiAddrT SENSOR_BASE = 32'h1000_0000;
    localparam axiTypesPkg::axiAddrT SENSOR_LIMIT = 32'h1000_03FF;

    localparam axiTypesPkg::axiAddrT WDT_BASE = 32'h1001_0000;
    localparam axiTypesPkg::axiAddrT WDT_LIMIT = 32'h1001_03FF;

    // 2 MB external memory
    localparam axiTypesPkg::axiAddrT DRAM_BASE = 32'h2000_0000;
    localparam axiTypesPkg::axiAddrT DRAM_LIMIT = 32'h201F_FFFF;

endpackage

// ==== rtl/raArbiter.sv ====
`timescale 1ns/100ps

module raArbiter (
    input  logic clk,
    input  logic rstN,
    input  logic arValidM0,
    input  logic arValidM1,
    input  logic reqTaken,
    output logic arReadyM0,
    output logic arReadyM1,
    output logic loadReq,
    output logic grantSel,
    output logic reqPending
);

    typedef enum logic {
        IDLE,
        SEND
    } stateT;

    stateT state;
    stateT stateNext;

    // index of the master granted last time
    logic lastGrant;
    logic anyValid;
    logic winner;

    assign anyValid = arValidM0 | arValidM1;

    // both valid: the master not granted last wins
    assign winner = (arValidM0 && arValidM1) ? ~lastGrant : arValidM1;

    // accept a master only while no request is outstanding
    assign loadReq = (state == IDLE) && anyValid;

    assign arReadyM0 = loadReq && !winner;
    assign arReadyM1 = loadReq && winner;
    assign grantSel = winner;

    assign reqPending = (state == SEND);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (anyValid) begin
                    stateNext = SEND;
                end
            end
            SEND: begin
                // wait for the selected slave to accept
                if (reqTaken) begin
                    stateNext = IDLE;
                end
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            // pretend M1 went last so M0 is favoured first
            lastGrant <= 1'b1;
        end else begin
            state <= stateNext;
            if (loadReq) begin
                lastGrant <= winner;
            end
        end
    end

endmodule

// ==== rtl/raRequestHold.sv ====
`timescale 1ns/100ps
`include "axi_settings.svh"

module raRequestHold (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  loadReq,
    input  logic                  grantSel,
    input  axiTypesPkg::axiMidT   arIdM0,
    input  axiTypesPkg::axiMidT   arIdM1,
    input  axiTypesPkg::axiAddrT  arAddrM0,
    input  axiTypesPkg::axiAddrT  arAddrM1,
    input  axiTypesPkg::axiLenT   arLenM0,
    input  axiTypesPkg::axiLenT   arLenM1,
    input  axiTypesPkg::axiSizeT  arSizeM0,
    input  axiTypesPkg::axiSizeT  arSizeM1,
    input  axiTypesPkg::axiBurstT arBurstM0,
    input  axiTypesPkg::axiBurstT arBurstM1,
    output axiTypesPkg::axiSidT   arIdS,
    output axiTypesPkg::axiAddrT  arAddrS,
    output axiTypesPkg::axiLenT   arLenS,
    output axiTypesPkg::axiSizeT  arSizeS,
    output axiTypesPkg::axiBurstT arBurstS
);

    import axiTypesPkg::*;

    // granted master's fields
    axiMidT idSel;
    axiAddrT addrSel;
    axiLenT lenSel;
    axiSizeT sizeSel;
    axiBurstT burstSel;
    axiSidT sidSel;

    assign idSel = grantSel ? arIdM1 : arIdM0;
    assign addrSel = grantSel ? arAddrM1 : arAddrM0;
    assign lenSel = grantSel ? arLenM1 : arLenM0;
    assign sizeSel = grantSel ? arSizeM1 : arSizeM0;
    assign burstSel = grantSel ? arBurstM1 : arBurstM0;

    // master index zero-extended into the upper nibble
    assign sidSel = {{(`RA_SID_W - `RA_MID_W - 1){1'b0}}, grantSel, idSel};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            arIdS <= '0;
            arAddrS <= '0;
            arLenS <= '0;
            arSizeS <= '0;
            arBurstS <= '0;
        end else if (loadReq) begin
            // held until the next grant
            arIdS <= sidSel;
            arAddrS <= addrSel;
            arLenS <= lenSel;
            arSizeS <= sizeSel;
            arBurstS <= burstSel;
        end
    end

endmodule

// ==== rtl/raAddrDecoder.sv ====
`timescale 1ns/100ps
`include "axi_settings.svh"

module raAddrDecoder (
    input  axiTypesPkg::axiAddrT     arAddrS,
    input  logic                     reqPending,
    input  logic [`RA_NUM_SLAVES-1:0] arReadyS,
    output logic [`RA_NUM_SLAVES-1:0] arValidS,
    output logic                     reqTaken
);

    import axiTypesPkg::*;
    import addrMapPkg::*;

    slaveSelT sel;

    function automatic logic inRegion(axiAddrT addr, axiAddrT base, axiAddrT limit);
        return (addr >= base) && (addr <= limit);
    endfunction

    // region lookup, anything unmapped falls to the default slave
    always_comb begin
        if (inRegion(arAddrS, ROM_BASE, ROM_LIMIT)) begin
            sel = SEL_ROM;
        end else if (inRegion(arAddrS, IM_BASE, IM_LIMIT)) begin
            sel = SEL_IM;
        end else if (inRegion(arAddrS, DM_BASE, DM_LIMIT)) begin
            sel = SEL_DM;
        end else if (inRegion(arAddrS, DRAM_BASE, DRAM_LIMIT)) begin
            sel = SEL_DRAM;
        end else if (inRegion(arAddrS, SENSOR_BASE, SENSOR_LIMIT)) begin
            sel = SEL_SENSOR;
        end else if (inRegion(arAddrS, WDT_BASE, WDT_LIMIT)) begin
            sel = SEL_WDT;
        end else begin
            sel = SEL_DEFAULT;
        end
    end

    // one valid bit, only while a request waits
    always_comb begin
        arValidS = '0;
        if (reqPending) begin
            arValidS[sel] = 1'b1;
        end
    end

    // ready from the addressed slave only
    assign reqTaken = arReadyS[sel];

endmodule

// ==== rtl/readAddrChannel.sv ====
`timescale 1ns/100ps
`include "axi_settings.svh"

module readAddrChannel (
    input  logic                      clk,
    input  logic                      rstN,
    // master 0
    input  axiTypesPkg::axiMidT       arIdM0,
    input  axiTypesPkg::axiAddrT      arAddrM0,
    input  axiTypesPkg::axiLenT       arLenM0,
    input  axiTypesPkg::axiSizeT      arSizeM0,
    input  axiTypesPkg::axiBurstT     arBurstM0,
    input  logic                      arValidM0,
    output logic                      arReadyM0,
    // master 1
    input  axiTypesPkg::axiMidT       arIdM1,
    input  axiTypesPkg::axiAddrT      arAddrM1,
    input  axiTypesPkg::axiLenT       arLenM1,
    input  axiTypesPkg::axiSizeT      arSizeM1,
    input  axiTypesPkg::axiBurstT     arBurstM1,
    input  logic                      arValidM1,
    output logic                      arReadyM1,
    // shared slave fields
    output axiTypesPkg::axiSidT       arIdS,
    output axiTypesPkg::axiAddrT      arAddrS,
    output axiTypesPkg::axiLenT       arLenS,
    output axiTypesPkg::axiSizeT      arSizeS,
    output axiTypesPkg::axiBurstT     arBurstS,
    output logic [`RA_NUM_SLAVES-1:0] arValidS,
    input  logic [`RA_NUM_SLAVES-1:0] arReadyS
);

    logic loadReq;
    logic grantSel;
    logic reqPending;
    logic reqTaken;

    raArbiter arbiter (
        .clk        (clk),
        .rstN       (rstN),
        .arValidM0  (arValidM0),
        .arValidM1  (arValidM1),
        .reqTaken   (reqTaken),
        .arReadyM0  (arReadyM0),
        .arReadyM1  (arReadyM1),
        .loadReq    (loadReq),
        .grantSel   (grantSel),
        .reqPending (reqPending)
    );

    raRequestHold requestHold (
        .clk       (clk),
        .rstN      (rstN),
        .loadReq   (loadReq),
        .grantSel  (grantSel),
        .arIdM0    (arIdM0),
        .arIdM1    (arIdM1),
        .arAddrM0  (arAddrM0),
        .arAddrM1  (arAddrM1),
        .arLenM0   (arLenM0),
        .arLenM1   (arLenM1),
        .arSizeM0  (arSizeM0),
        .arSizeM1  (arSizeM1),
        .arBurstM0 (arBurstM0),
        .arBurstM1 (arBurstM1),
        .arIdS     (arIdS),
        .arAddrS   (arAddrS),
        .arLenS    (arLenS),
        .arSizeS   (arSizeS),
        .arBurstS  (arBurstS)
    );

    // decodes from the held address, not the master's
    raAddrDecoder addrDecoder (
        .arAddrS    (arAddrS),
        .reqPending (reqPending),
        .arReadyS   (arReadyS),
        .arValidS   (arValidS),
        .reqTaken   (reqTaken)
    );

endmodule

// ==== sim/readAddrChannel_assertions.sv ====
`timescale 1ns/100ps
`include "axi_settings.svh"

module readAddrChannelAssertions (
    input logic                      clk,
    input logic                      rstN,
    input logic                      arReadyM0,
    input logic                      arReadyM1,
    input axiTypesPkg::axiSidT       arIdS,
    input axiTypesPkg::axiAddrT      arAddrS,
    input axiTypesPkg::axiLenT       arLenS,
    input axiTypesPkg::axiSizeT      arSizeS,
    input axiTypesPkg::axiBurstT     arBurstS,
    input logic [`RA_NUM_SLAVES-1:0] arValidS,
    input logic [`RA_NUM_SLAVES-1:0] arReadyS
);

    // at most one slave addressed
    validOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(arValidS))
        else $error("more than one slave valid at once");

    // a stalled request keeps its valid and fields
    heldUnderStall: assert property (@(posedge clk) disable iff (!rstN)
        ((arValidS & ~arReadyS) != '0) |=>
            ($stable(arValidS) && $stable({arIdS, arAddrS, arLenS, arSizeS, arBurstS})))
        else $error("slave request changed before the slave accepted it");

    // masters wait while a request sits at a slave
    noGrantWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        (arValidS != '0) |-> !(arReadyM0 || arReadyM1))
        else $error("master accepted while a slave valid is high");

endmodule

bind readAddrChannel readAddrChannelAssertions handshakeChecks (.*);

// ==== sim/tbReadAddrChannel.sv ====
`timescale 1ns/100ps
`include "axi_settings.svh"

module tbReadAddrChannel;

    import axiTypesPkg::*;
    import addrMapPkg::*;

    localparam int TIMEOUT = 100;
    localparam int NUM_ADDR = 15;

    typedef struct packed {
        slaveSelT sel;
        axiSidT sid;
        axiAddrT addr;
        axiLenT len;
        axiSizeT size;
        axiBurstT burst;
    } expItemT;

    logic clk = 1'b0;
    logic rstN;
    axiMidT arIdM0, arIdM1;
    axiAddrT arAddrM0, arAddrM1, arAddrS;
    axiLenT arLenM0, arLenM1, arLenS;
    axiSizeT arSizeM0, arSizeM1, arSizeS;
    axiBurstT arBurstM0, arBurstM1, arBurstS;
    axiSidT arIdS;
    logic arValidM0, arValidM1, arReadyM0, arReadyM1;
    logic [`RA_NUM_SLAVES-1:0] arValidS;
    logic [`RA_NUM_SLAVES-1:0] arReadyS = '0;

    integer seed = 32'h2dc3_bb90;
    expItemT expQ [$];
    logic verdictShown = 1'b0;
    logic checkOrder = 1'b0;
    logic nextMaster = 1'b0;
    logic slaveReady = 1'b0;
    int slaveDelay = 0;
    logic [31:0] noise;

    // mapped addresses first and five unmapped ones at the end
    axiAddrT addrList [NUM_ADDR] = '{
        32'h0000_0000, 32'h0000_3FFC, 32'h0001_0000, 32'h0001_FFFC, 32'h0002_8000,
        32'h2000_0000, 32'h201F_FFFC, 32'h1000_0010, 32'h1000_03FC, 32'h1001_0000,
        32'h0000_4000, 32'h0003_0000, 32'h1000_0400, 32'h2020_0000, 32'hFFFF_FFF0
    };

    readAddrChannel UUT (.*);

    always #50 clk = ~clk;

    // expected slave and tagged ID from the region sizes of the address map
    function automatic expItemT expectedItem(input axiAddrT addr, input axiMidT id,
            input axiLenT len, input axiSizeT size, input axiBurstT burst, input logic m);
        expItemT e;
        e = '{SEL_DEFAULT, {3'b000, m, id}, addr, len, size, burst};
        if (addr[31:14] == 18'h0) e.sel = SEL_ROM;
        if (addr[31:16] == 16'h0001) e.sel = SEL_IM;
        if (addr[31:16] == 16'h0002) e.sel = SEL_DM;
        if (addr[31:21] == 11'h100) e.sel = SEL_DRAM;
        if (addr[31:10] == 22'h04_0000) e.sel = SEL_SENSOR;
        if (addr[31:10] == 22'h04_0040) e.sel = SEL_WDT;
        return e;
    endfunction

    function automatic axiAddrT pickAddr();
        int idx;
        idx = $unsigned($random(seed)) % NUM_ADDR;
        return addrList[idx];
    endfunction

    task automatic abortRun();
        verdictShown = 1'b1;
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkSel(input slaveSelT expected, input slaveSelT actual);
        if (actual !== expected) begin
            $display("error arValidS select: expected 0x%h got 0x%h", expected, actual);
            abortRun();
        end
    endtask

    task automatic checkSid(input axiSidT expected, input axiSidT actual);
        if (actual !== expected) begin
            $display("error arIdS: expected 0x%h got 0x%h", expected, actual);
            abortRun();
        end
    endtask

    task automatic checkAddr(input axiAddrT expected, input axiAddrT actual);
        if (actual !== expected) begin
            $display("error arAddrS: expected 0x%h got 0x%h", expected, actual);
            abortRun();
        end
    endtask

    task automatic checkCtl(input axiLenT expLen, input axiSizeT expSize,
            input axiBurstT expBurst, input axiLenT len, input axiSizeT size,
            input axiBurstT burst);
        if ({len, size, burst} !== {expLen, expSize, expBurst}) begin
            $display("error arLenS/arSizeS/arBurstS: expected 0x%h/0x%h/0x%h got 0x%h/0x%h/0x%h",
                expLen, expSize, expBurst, len, size, burst);
            abortRun();
        end
    endtask

    // one request from master m issued just after a rising edge
    task automatic sendReq(input logic m, input axiAddrT addr, input axiMidT id);
        int cnt;
        logic ready;
        axiLenT len;
        axiSizeT size;
        axiBurstT burst;
        len = axiLenT'($random(seed));
        size = axiSizeT'($random(seed));
        burst = axiBurstT'($random(seed));
        if (m) begin
            {arIdM1, arAddrM1, arLenM1, arSizeM1, arBurstM1, arValidM1} =
                {id, addr, len, size, burst, 1'b1};
        end else begin
            {arIdM0, arAddrM0, arLenM0, arSizeM0, arBurstM0, arValidM0} =
                {id, addr, len, size, burst, 1'b1};
        end
        cnt = 0;
        // ready is combinational so look mid-cycle
        do begin
            @(negedge clk);
            ready = m ? arReadyM1 : arReadyM0;
            cnt++;
        end while (!ready && (cnt < TIMEOUT));
        if (!ready) begin
            $display("master %0d was not accepted within %0d cycles", m, TIMEOUT);
            abortRun();
        end
        if (checkOrder && (m !== nextMaster)) begin
            $display("error arReadyM grant: expected master 0x%h got 0x%h", nextMaster, m);
            abortRun();
        end
        nextMaster = ~m;
        expQ.push_back(expectedItem(addr, id, len, size, burst, m));
        @(posedge clk);
        #10;
        // drop only this master's valid
        arValidM0 = arValidM0 && m;
        arValidM1 = arValidM1 && !m;
    endtask

    task automatic randomTraffic(input logic m);
        int gap;
        for (int i = 0; i < 20; i++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                #10;
            end
            sendReq(m, pickAddr(), axiMidT'($random(seed)));
        end
    endtask

    task automatic waitDrain();
        int cnt;
        cnt = 0;
        while ((expQ.size() != 0) && (cnt < TIMEOUT)) begin
            @(negedge clk);
            cnt++;
        end
        if (expQ.size() != 0) begin
            $display("%0d accepted requests never reached a slave", expQ.size());
            abortRun();
        end
    endtask

    // slave ready after 0 to 3 cycles with noise on the slaves not addressed
    always @(posedge clk) begin
        #10;
        if (!rstN) begin
            slaveReady = 1'b0;
        end else if (slaveReady) begin
            slaveReady = 1'b0;
            slaveDelay = $unsigned($random(seed)) % 4;
        end else if (arValidS != '0) begin
            if (slaveDelay == 0) begin
                slaveReady = 1'b1;
            end else begin
                slaveDelay--;
            end
        end
        noise = $random(seed);
        arReadyS = slaveReady ? arValidS : (noise[`RA_NUM_SLAVES-1:0] & ~arValidS);
    end

    // slave handshake compared before the edge that completes it
    always @(negedge clk) begin : slaveMonitor
        expItemT item;
        slaveSelT gotSel;
        if (rstN && ((arValidS & arReadyS) != '0)) begin
            if (expQ.size() == 0) begin
                $display("a slave took a request that no master had issued");
                abortRun();
            end else begin
                item = expQ.pop_front();
                gotSel = SEL_DEFAULT;
                for (int i = 0; i < `RA_NUM_SLAVES; i++) begin
                    if (arValidS[i]) gotSel = slaveSelT'(i);
                end
                checkSel(item.sel, gotSel);
                checkSid(item.sid, arIdS);
                checkAddr(item.addr, arAddrS);
                checkCtl(item.len, item.size, item.burst, arLenS, arSizeS, arBurstS);
            end
        end
    end

    initial begin
        rstN = 1'b0;
        {arIdM0, arAddrM0, arLenM0, arSizeM0, arBurstM0, arValidM0} = '0;
        {arIdM1, arAddrM1, arLenM1, arSizeM1, arBurstM1, arValidM1} = '0;
        repeat (4) @(posedge clk);
        #10;
        rstN = 1'b1;
        @(negedge clk);
        if (({arReadyM1, arReadyM0} !== 2'b00) || (arValidS !== '0)) begin
            $display("error arReadyM 0x%h arValidS 0x%h: expected zero after reset",
                {arReadyM1, arReadyM0}, arValidS);
            abortRun();
        end
        @(posedge clk);
        #10;
        // both masters stay valid and grants alternate starting with M0
        checkOrder = 1'b1;
        fork
            for (int i = 0; i < 6; i++) sendReq(1'b0, pickAddr(), axiMidT'(i));
            for (int i = 0; i < 6; i++) sendReq(1'b1, pickAddr(), axiMidT'(i + 8));
        join
        checkOrder = 1'b0;
        // whole address list with the masters taking turns
        for (int i = 0; i < NUM_ADDR; i++) begin
            sendReq(i[0], addrList[i], axiMidT'(i));
        end
        fork
            randomTraffic(1'b0);
            randomTraffic(1'b1);
        join
        waitDrain();
        // no request may be offered again after the last delivery
        @(negedge clk);
        if (arValidS !== '0) begin
            $display("error arValidS: expected 0x%h got 0x%h after the last delivery",
                7'h00, arValidS);
            abortRun();
        end else begin
            verdictShown = 1'b1;
            $display("TEST PASSED");
            $finish;
        end
    end

    final begin
        if (!verdictShown) begin
            $display("TEST FAILED");
        end
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/axiTypesPkg.sv
rtl/addrMapPkg.sv
rtl/raArbiter.sv
rtl/raRequestHold.sv
rtl/raAddrDecoder.sv
rtl/readAddrChannel.sv
sim/readAddrChannel_assertions.sv
sim/tbReadAddrChannel.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the read address channel testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f verilog.f --top-module tbReadAddrChannel \
    -o simv > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
grep -q "TEST PASSED" sim.log || exit 1
exit 0
